/* logic/mmu_params.svh */
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// data path and address widths
`define MMU_DATA_W       16
`define MMU_PA_W         22
`define MMU_PAGES        8

// register offsets within the I/O page
`define MMU_SR0_ADDR     13'o17572
`define MMU_SR3_ADDR     13'o12516
`define MMU_KSET         7'o123       // kernel PAR/PDR set, addr[12:6]
`define MMU_USET         7'o176       // user PAR/PDR set, addr[12:6]

// PDR bits that read back
`define MMU_PDR_RD_MASK  16'o077516

// PDR field positions
`define PDR_PLF_HI       14
`define PDR_PLF_LO       8
`define PDR_W            6            // dirty page
`define PDR_ED           3            // expansion direction
`define PDR_ACF_WR       2
`define PDR_ACF_RES      1

`endif

/* logic/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

   // virtual address, seen whole or split into page fields
   typedef union packed
   {
      logic [15:0] raw;
      struct packed
      {
         logic [2:0] apf;             // active page field
         logic [6:0] blk;             // block number within the page
         logic [5:0] disp;            // displacement within the block
      } f;
   } va_t;

endpackage

`default_nettype wire

/* logic/mmu_ifs.sv */
`default_nettype none

// host register access from the sequencer to the register files
interface mmu_host_if;
   logic        wr_stb;
   logic        rd_stb;
   logic [1:0]  be;
   logic [15:0] wdata;
   logic [3:0]  page_sel;             // {user, page}
   logic        par_sel;              // 1 - PAR, 0 - PDR
   logic        pf_sel;
   logic        sr0_sel;
   logic        sr3_sel;
   logic [15:0] rdata_pf;
   logic [15:0] rdata_sr;

   modport ctrl (output wr_stb, rd_stb, be, wdata, page_sel, par_sel, pf_sel,
                 sr0_sel, sr3_sel, input rdata_pf, rdata_sr);
   modport regs (input wr_stb, rd_stb, be, wdata, page_sel, par_sel, pf_sel,
                 sr0_sel, sr3_sel, output rdata_pf, rdata_sr);
endinterface

// page lookup for translation and W bit update
interface mmu_page_if;
   logic        lk_stb;
   logic [3:0]  lk_page;
   logic        set_w;
   logic [15:0] par_word;
   logic [15:0] pdr_word;

   modport xlate (output lk_stb, lk_page, set_w, input par_word, pdr_word);
   modport regs (input lk_stb, lk_page, set_w, output par_word, pdr_word);
endinterface

// status register state and abort report
interface mmu_status_if;
   logic        mmu_en;
   logic        en_22;
   logic        frozen;
   logic        upd_stb;
   logic        upd_user;
   logic [2:0]  upd_page;
   logic [2:0]  abt_reasons;          // {nr, le, ro}

   modport xlate (input mmu_en, en_22, frozen,
                  output upd_stb, upd_user, upd_page, abt_reasons);
   modport status (output mmu_en, en_22, frozen,
                   input upd_stb, upd_user, upd_page, abt_reasons);
endinterface

`default_nettype wire

/* logic/mmu_bus_ctrl.sv */
`default_nettype none
`include "mmu_params.svh"

module mmu_bus_ctrl
   import mmu_pkg::*;
(
   input  logic                   clk,
   input  logic                   sr_rst,
   input  logic                   reg_req,
   input  logic                   reg_we,
   input  logic [12:0]            reg_addr,
   input  logic [1:0]             reg_be,
   input  logic [`MMU_DATA_W-1:0] reg_wdata,
   output logic                   reg_ack,
   output logic [`MMU_DATA_W-1:0] reg_rdata,
   output logic                   reg_hit,
   input  logic                   xl_req,
   input  logic                   xl_write,
   input  logic                   xl_user,
   input  va_t                    xl_va,
   output logic                   xl_ack,
   input  logic                   xl_done,
   mmu_host_if.ctrl               host,
   output logic                   xl_go,
   output va_t                    xl_va_q,
   output logic                   xl_write_q,
   output logic                   xl_user_q
);

localparam logic [2:0] S_IDLE  = 3'd0;
localparam logic [2:0] S_RDEC  = 3'd1;  // register address decode
localparam logic [2:0] S_RSTB  = 3'd2;  // read/write strobe
localparam logic [2:0] S_RACK  = 3'd3;
localparam logic [2:0] S_XGO   = 3'd4;  // page lookup start
localparam logic [2:0] S_XWAIT = 3'd5;
localparam logic [2:0] S_XACK  = 3'd6;

logic [2:0]             state;
logic [12:0]            addr_q;
logic                   we_q;
logic [1:0]             be_q;
logic [`MMU_DATA_W-1:0] wdata_q;
logic                   dec_kset;
logic                   dec_uset;
logic                   dec_sr0;
logic                   dec_sr3;
logic                   pf_sel_q;
logic                   par_sel_q;
logic                   sr0_sel_q;
logic                   sr3_sel_q;
logic [3:0]             page_sel_q;

// bit 4 must be clear inside a PAR/PDR set
always_comb
begin
   dec_kset = (addr_q[12:6] == `MMU_KSET) & ~addr_q[4];
   dec_uset = (addr_q[12:6] == `MMU_USET) & ~addr_q[4];
   dec_sr0  = ({addr_q[12:1], 1'b0} == `MMU_SR0_ADDR);
   dec_sr3  = ({addr_q[12:1], 1'b0} == `MMU_SR3_ADDR);
end

always_ff @(posedge clk)
begin
   if (sr_rst)
   begin
      state      <= S_IDLE;
      reg_ack    <= 1'b0;
      xl_ack     <= 1'b0;
      pf_sel_q   <= 1'b0;
      par_sel_q  <= 1'b0;
      sr0_sel_q  <= 1'b0;
      sr3_sel_q  <= 1'b0;
      page_sel_q <= 4'd0;
   end
   else
   begin
      case (state)
         S_IDLE:
         begin
            if (reg_req)
               state <= S_RDEC;            // register channel wins
            else if (xl_req)
               state <= S_XGO;
         end
         S_RDEC:
         begin
            pf_sel_q   <= dec_kset | dec_uset;
            par_sel_q  <= addr_q[5];
            sr0_sel_q  <= dec_sr0;
            sr3_sel_q  <= dec_sr3;
            page_sel_q <= {dec_uset, addr_q[3:1]};
            state      <= S_RSTB;
         end
         S_RSTB:
         begin
            reg_ack <= 1'b1;
            state   <= S_RACK;
         end
         S_RACK:
         begin
            if (!reg_req)
            begin
               reg_ack   <= 1'b0;
               pf_sel_q  <= 1'b0;
               sr0_sel_q <= 1'b0;
               sr3_sel_q <= 1'b0;
               state     <= S_IDLE;
            end
         end
         S_XGO:
            state <= S_XWAIT;
         S_XWAIT:
         begin
            if (xl_done)
            begin
               xl_ack <= 1'b1;
               state  <= S_XACK;
            end
         end
         S_XACK:
         begin
            if (!xl_req)
            begin
               xl_ack <= 1'b0;
               state  <= S_IDLE;
            end
         end
         default:
            state <= S_IDLE;
      endcase
   end
end

// request capture, last idle cycle holds
always_ff @(posedge clk)
begin
   if (state == S_IDLE)
   begin
      addr_q     <= reg_addr;
      we_q       <= reg_we;
      be_q       <= reg_be;
      wdata_q    <= reg_wdata;
      xl_va_q    <= xl_va;
      xl_write_q <= xl_write;
      xl_user_q  <= xl_user;
   end
end

assign host.wr_stb   = (state == S_RSTB) & we_q;
assign host.rd_stb   = (state == S_RSTB) & ~we_q;
assign host.be       = be_q;
assign host.wdata    = wdata_q;
assign host.page_sel = page_sel_q;
assign host.par_sel  = par_sel_q;
assign host.pf_sel   = pf_sel_q;
assign host.sr0_sel  = sr0_sel_q;
assign host.sr3_sel  = sr3_sel_q;

assign reg_hit   = pf_sel_q | sr0_sel_q | sr3_sel_q;
assign reg_rdata = host.rdata_pf | host.rdata_sr;   // unselected sources read 0
assign xl_go     = (state == S_XGO);

endmodule

`default_nettype wire

/* logic/mmu_page_regs.sv */
`default_nettype none
`include "mmu_params.svh"

module mmu_page_regs
(
   input  logic     clk,
   input  logic     sr_rst,
   mmu_host_if.regs host,
   mmu_page_if.regs page
);

logic [`MMU_DATA_W-1:0] par [2*`MMU_PAGES];   // kernel 0..7, user 8..15
logic [`MMU_DATA_W-1:0] pdr [2*`MMU_PAGES];
logic [`MMU_DATA_W-1:0] par_rd;
logic [`MMU_DATA_W-1:0] pdr_rd;

always_ff @(posedge clk)
begin
   if (sr_rst)
   begin
      for (int i = 0; i < 2*`MMU_PAGES; i++)
      begin
         par[i] <= '0;
         pdr[i] <= '0;
      end
   end
   else
   begin
      if (host.wr_stb && host.pf_sel)
      begin
         if (host.par_sel)
         begin
            if (host.be[0])
               par[host.page_sel][7:0] <= host.wdata[7:0];
            if (host.be[1])
               par[host.page_sel][15:8] <= host.wdata[15:8];
         end
         else
         begin
            // only PLF, ED and ACF are writable
            if (host.be[1])
               pdr[host.page_sel][`PDR_PLF_HI:`PDR_PLF_LO] <=
                  host.wdata[`PDR_PLF_HI:`PDR_PLF_LO];
            if (host.be[0])
               pdr[host.page_sel][`PDR_ED:`PDR_ACF_RES] <=
                  host.wdata[`PDR_ED:`PDR_ACF_RES];
         end
         pdr[host.page_sel][`PDR_W] <= 1'b0;          // any page write clears W
      end
      else if (page.set_w)
         pdr[page.lk_page][`PDR_W] <= 1'b1;           // written through
   end
end

assign par_rd = par[host.page_sel];
assign pdr_rd = pdr[host.page_sel] & `MMU_PDR_RD_MASK;

always_ff @(posedge clk)
begin
   if (host.rd_stb)
   begin
      if (!host.pf_sel)
         host.rdata_pf <= '0;
      else if (host.par_sel)
         host.rdata_pf <= par_rd;
      else
         host.rdata_pf <= pdr_rd;
   end
end

// translation lookup
always_ff @(posedge clk)
begin
   if (page.lk_stb)
   begin
      page.par_word <= par[page.lk_page];
      page.pdr_word <= pdr[page.lk_page];
   end
end

endmodule

`default_nettype wire

/* logic/mmu_status_regs.sv */
`default_nettype none
`include "mmu_params.svh"

module mmu_status_regs
(
   input  logic        clk,
   input  logic        sr_rst,
   mmu_host_if.regs    host,
   mmu_status_if.status stat
);

logic [2:0]             sr0_abt;      // {nr, le, ro} in bits 15..13
logic [1:0]             sr0_mode;     // bits 6..5
logic [2:0]             sr0_page;     // bits 3..1
logic                   sr0_en;
logic                   sr3_22;       // 22-bit mapping
logic [`MMU_DATA_W-1:0] sr0_word;
logic [`MMU_DATA_W-1:0] sr3_word;

always_ff @(posedge clk)
begin
   if (sr_rst)
   begin
      sr0_abt  <= 3'b000;
      sr0_mode <= 2'b00;
      sr0_page <= 3'b000;
      sr0_en   <= 1'b0;
      sr3_22   <= 1'b0;
   end
   else
   begin
      if (host.wr_stb && host.sr0_sel)
      begin
         if (host.be[1])
            sr0_abt <= host.wdata[15:13];
         if (host.be[0])
            sr0_en <= host.wdata[0];
      end
      else if (stat.upd_stb && !stat.frozen)
      begin
         sr0_mode <= {2{stat.upd_user}};
         sr0_page <= stat.upd_page;
         sr0_abt  <= sr0_abt | stat.abt_reasons;
      end

      if (host.wr_stb && host.sr3_sel && host.be[0])
         sr3_22 <= host.wdata[4];
   end
end

assign sr0_word = {sr0_abt, 6'b000000, sr0_mode, 1'b0, sr0_page, sr0_en};
assign sr3_word = {11'd0, sr3_22, 4'b0000};

always_ff @(posedge clk)
begin
   if (host.rd_stb)
   begin
      if (host.sr0_sel)
         host.rdata_sr <= sr0_word;
      else if (host.sr3_sel)
         host.rdata_sr <= sr3_word;
      else
         host.rdata_sr <= '0;
   end
end

assign stat.mmu_en = sr0_en;
assign stat.en_22  = sr3_22;
assign stat.frozen = |sr0_abt;     // held until the host clears the reasons

endmodule

`default_nettype wire

/* logic/mmu_xlate.sv */
`default_nettype none
`include "mmu_params.svh"

module mmu_xlate
   import mmu_pkg::*;
(
   input  logic                 clk,
   input  logic                 sr_rst,
   input  logic                 go,
   input  va_t                  va,
   input  logic                 write,
   input  logic                 user,
   output logic                 done,
   output logic [`MMU_PA_W-1:0] pa,
   output logic                 abort,
   mmu_page_if.xlate            page,
   mmu_status_if.xlate          stat
);

logic                   s1_vld;       // lookup data valid
logic [`MMU_DATA_W-1:0] base;
logic [`MMU_PA_W-1:0]   pa_map;
logic [6:0]             plf;
logic                   nr;
logic                   ro;
logic                   le;
logic [2:0]             reasons;
logic                   upd_q;
logic                   set_w_q;
logic [2:0]             reasons_q;

assign page.lk_stb  = go;
assign page.lk_page = {user, va.f.apf};

// page address adder and limit check
always_comb
begin
   plf    = page.pdr_word[`PDR_PLF_HI:`PDR_PLF_LO];
   base   = page.par_word + {9'd0, va.f.blk};
   pa_map = {base, va.f.disp};
   if (!stat.en_22)
      pa_map[21:18] = 4'b0000;                  // 18-bit mode
   nr = ~page.pdr_word[`PDR_ACF_RES];
   ro = write & ~page.pdr_word[`PDR_ACF_WR];
   if (page.pdr_word[`PDR_ED])
      le = (va.f.blk < plf);                    // downward page
   else
      le = (va.f.blk > plf);
   reasons = stat.mmu_en ? {nr, le, ro} : 3'b000;
end

always_ff @(posedge clk)
begin
   if (sr_rst)
   begin
      s1_vld    <= 1'b0;
      done      <= 1'b0;
      abort     <= 1'b0;
      upd_q     <= 1'b0;
      set_w_q   <= 1'b0;
      reasons_q <= 3'b000;
   end
   else
   begin
      s1_vld  <= go;
      done    <= s1_vld;
      upd_q   <= s1_vld & stat.mmu_en;
      set_w_q <= s1_vld & stat.mmu_en & write & ~|reasons;
      if (s1_vld)
      begin
         abort     <= |reasons;
         reasons_q <= reasons;
      end
   end
end

always_ff @(posedge clk)
begin
   if (s1_vld)
   begin
      if (stat.mmu_en)
         pa <= pa_map;
      else
         pa <= {{(`MMU_PA_W-`MMU_DATA_W){1'b0}}, va.raw};   // unmapped
   end
end

assign page.set_w       = set_w_q;
assign stat.upd_stb     = upd_q;
assign stat.upd_user    = user;
assign stat.upd_page    = va.f.apf;
assign stat.abt_reasons = reasons_q;

endmodule

`default_nettype wire

/* logic/mmu_top.sv */
`default_nettype none

module mmu_top
   import mmu_pkg::*;
(
   input  logic        clk,
   input  logic        sr_rst,
   input  logic        reg_req,
   input  logic        reg_we,
   input  logic [12:0] reg_addr,
   input  logic [1:0]  reg_be,
   input  logic [15:0] reg_wdata,
   output logic        reg_ack,
   output logic [15:0] reg_rdata,
   output logic        reg_hit,
   input  logic        xl_req,
   input  logic        xl_write,
   input  logic        xl_user,
   input  va_t         xl_va,
   output logic        xl_ack,
   output logic        xl_abort,
   output logic [21:0] xl_pa
);

logic xl_go;
va_t  xl_va_q;
logic xl_write_q;
logic xl_user_q;
logic xl_done;

mmu_host_if   host_if ();
mmu_page_if   page_if ();
mmu_status_if stat_if ();

mmu_bus_ctrl u_bus_ctrl
(
   .clk        (clk),
   .sr_rst     (sr_rst),
   .reg_req    (reg_req),
   .reg_we     (reg_we),
   .reg_addr   (reg_addr),
   .reg_be     (reg_be),
   .reg_wdata  (reg_wdata),
   .reg_ack    (reg_ack),
   .reg_rdata  (reg_rdata),
   .reg_hit    (reg_hit),
   .xl_req     (xl_req),
   .xl_write   (xl_write),
   .xl_user    (xl_user),
   .xl_va      (xl_va),
   .xl_ack     (xl_ack),
   .xl_done    (xl_done),
   .host       (host_if.ctrl),
   .xl_go      (xl_go),
   .xl_va_q    (xl_va_q),
   .xl_write_q (xl_write_q),
   .xl_user_q  (xl_user_q)
);

mmu_page_regs u_page_regs
(
   .clk    (clk),
   .sr_rst (sr_rst),
   .host   (host_if.regs),
   .page   (page_if.regs)
);

mmu_status_regs u_status_regs
(
   .clk    (clk),
   .sr_rst (sr_rst),
   .host   (host_if.regs),
   .stat   (stat_if.status)
);

mmu_xlate u_xlate
(
   .clk    (clk),
   .sr_rst (sr_rst),
   .go     (xl_go),
   .va     (xl_va_q),
   .write  (xl_write_q),
   .user   (xl_user_q),
   .done   (xl_done),
   .pa     (xl_pa),
   .abort  (xl_abort),
   .page   (page_if.xlate),
   .stat   (stat_if.xlate)
);

endmodule

`default_nettype wire

/* sim/tb_mmu.sv */
`default_nettype none
`include "mmu_params.svh"

module tb_mmu
   import mmu_pkg::*;
();

localparam int N_REGS      = 2 + 4*`MMU_PAGES;     // SR0, SR3, all PARs and PDRs
localparam int N_RND       = 40;
localparam int N_XL        = 12;
localparam int N_ACCESS    = 3*N_REGS + N_RND + 3*N_XL + 60;
localparam int WDOG_CYCLES = N_ACCESS*10 + 100;

logic        clk;
logic        sr_rst;
logic        reg_req;
logic        reg_we;
logic [12:0] reg_addr;
logic [1:0]  reg_be;
logic [15:0] reg_wdata;
logic        reg_ack;
logic [15:0] reg_rdata;
logic        reg_hit;
logic        xl_req;
logic        xl_write;
logic        xl_user;
va_t         xl_va;
logic        xl_ack;
logic        xl_abort;
logic [21:0] xl_pa;

int seed = 38337;
int errors = 0;
int proto_errors = 0;

// reference model of the register state
logic [15:0] m_par [2*`MMU_PAGES];
logic [15:0] m_pdr [2*`MMU_PAGES];
logic [2:0]  m_abt;                    // SR0 15..13 as {nr, le, ro}
logic        m_user;
logic [2:0]  m_page;
logic        m_en;
logic        m_22;

logic reg_req_d;
logic reg_ack_d;
logic xl_req_d;
logic xl_ack_d;

mmu_top u_mmu_top
(
   .clk       (clk),
   .sr_rst    (sr_rst),
   .reg_req   (reg_req),
   .reg_we    (reg_we),
   .reg_addr  (reg_addr),
   .reg_be    (reg_be),
   .reg_wdata (reg_wdata),
   .reg_ack   (reg_ack),
   .reg_rdata (reg_rdata),
   .reg_hit   (reg_hit),
   .xl_req    (xl_req),
   .xl_write  (xl_write),
   .xl_user   (xl_user),
   .xl_va     (xl_va),
   .xl_ack    (xl_ack),
   .xl_abort  (xl_abort),
   .xl_pa     (xl_pa)
);

initial
begin
   clk = 1'b0;
   forever #50 clk = ~clk;
end

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
   assert (act === exp)
   else
   begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
   end
endtask

function automatic logic [12:0] page_addr(input logic usr, input logic is_par,
                                          input logic [2:0] pg);
   logic [6:0] set;
   set = usr ? `MMU_USET : `MMU_KSET;
   return {set, is_par, 1'b0, pg, 1'b0};
endfunction

function automatic logic [12:0] word_addr(input logic [12:0] addr);
   return {addr[12:1], 1'b0};            // byte address bit ignored
endfunction

// page number 0..15 for a PAR/PDR address or -1
function automatic int page_index(input logic [12:0] addr);
   if (addr[4])
      return -1;
   if (addr[12:6] == `MMU_KSET)
      return int'(addr[3:1]);
   if (addr[12:6] == `MMU_USET)
      return 8 + int'(addr[3:1]);
   return -1;
endfunction

function automatic logic model_hit(input logic [12:0] addr);
   return (page_index(addr) >= 0) || (word_addr(addr) == `MMU_SR0_ADDR) ||
          (word_addr(addr) == `MMU_SR3_ADDR);
endfunction

function automatic logic [15:0] model_read(input logic [12:0] addr);
   int          pg;
   logic [15:0] val;
   pg  = page_index(addr);
   val = 16'h0000;
   if (pg >= 0)
      val = addr[5] ? m_par[pg] : (m_pdr[pg] & `MMU_PDR_RD_MASK);
   else if (word_addr(addr) == `MMU_SR0_ADDR)
      val = {m_abt, 6'b000000, {2{m_user}}, 1'b0, m_page, m_en};
   else if (word_addr(addr) == `MMU_SR3_ADDR)
      val = {11'd0, m_22, 4'd0};
   return val;
endfunction

task automatic model_write(input logic [12:0] addr, input logic [1:0] be, input logic [15:0] d);
   int pg;
   pg = page_index(addr);
   if (pg >= 0)
   begin
      if (addr[5])
      begin
         if (be[0])
            m_par[pg][7:0] = d[7:0];
         if (be[1])
            m_par[pg][15:8] = d[15:8];
      end
      else
      begin
         if (be[1])
            m_pdr[pg][`PDR_PLF_HI:`PDR_PLF_LO] = d[`PDR_PLF_HI:`PDR_PLF_LO];
         if (be[0])
            m_pdr[pg][`PDR_ED:`PDR_ACF_RES] = d[`PDR_ED:`PDR_ACF_RES];
      end
      m_pdr[pg][`PDR_W] = 1'b0;
   end
   else if (word_addr(addr) == `MMU_SR0_ADDR)
   begin
      if (be[1])
         m_abt = d[15:13];
      if (be[0])
         m_en = d[0];
   end
   else if (word_addr(addr) == `MMU_SR3_ADDR && be[0])
      m_22 = d[4];
endtask

task automatic model_xlate(input logic [15:0] va, input logic wr, input logic usr,
                           output logic [21:0] pa, output logic abt);
   int          pg;
   logic [31:0] full;
   logic [6:0]  blk;
   logic [6:0]  plf;
   logic [15:0] pdr;
   logic        nr;
   logic        ro;
   logic        le;
   blk = va[12:6];
   pg  = int'({usr, va[15:13]});
   pdr = m_pdr[pg];
   plf = pdr[`PDR_PLF_HI:`PDR_PLF_LO];
   if (!m_en)
   begin
      pa  = {6'd0, va};
      abt = 1'b0;
   end
   else
   begin
      // PAR and block both count 64-byte units
      full = 32'(m_par[pg]) * 64 + 32'(blk) * 64 + 32'(va[5:0]);
      pa   = full[21:0];
      if (!m_22)
         pa[21:18] = 4'd0;
      nr  = !pdr[`PDR_ACF_RES];
      ro  = wr && !pdr[`PDR_ACF_WR];
      le  = pdr[`PDR_ED] ? (blk < plf) : (blk > plf);
      abt = nr || ro || le;
      if (m_abt == 3'b000)             // SR0 frozen once a reason is set
      begin
         m_user = usr;
         m_page = va[15:13];
         m_abt  = {nr, le, ro};
      end
      if (wr && !abt)
         m_pdr[pg][`PDR_W] = 1'b1;
   end
endtask

task automatic reg_access(input logic we, input logic [12:0] addr, input logic [1:0] be,
                          input logic [15:0] wdata, output logic [15:0] rdata,
                          output logic hit);
   int hold;
   hold = {$random(seed)} % 3;         // extra cycles with req kept high
   @(posedge clk);
   reg_req   <= 1'b1;
   reg_we    <= we;
   reg_addr  <= addr;
   reg_be    <= be;
   reg_wdata <= wdata;
   do
      @(posedge clk);
   while (reg_ack !== 1'b1);
   rdata = reg_rdata;
   hit   = reg_hit;
   repeat (hold) @(posedge clk);
   reg_req <= 1'b0;
   do
      @(posedge clk);
   while (reg_ack !== 1'b0);
endtask

task automatic xl_access(input logic [15:0] va, input logic wr, input logic usr,
                         output logic [21:0] pa, output logic abt);
   int hold;
   hold = {$random(seed)} % 3;
   @(posedge clk);
   xl_req   <= 1'b1;
   xl_va    <= va;
   xl_write <= wr;
   xl_user  <= usr;
   do
      @(posedge clk);
   while (xl_ack !== 1'b1);
   pa  = xl_pa;
   abt = xl_abort;
   repeat (hold) @(posedge clk);
   xl_req <= 1'b0;
   do
      @(posedge clk);
   while (xl_ack !== 1'b0);
endtask

task automatic reg_write(input logic [12:0] addr, input logic [1:0] be, input logic [15:0] d);
   logic [15:0] rd;
   logic        hit;
   reg_access(1'b1, addr, be, d, rd, hit);
   check_value("reg_hit", 32'(model_hit(addr)), 32'(hit));
   model_write(addr, be, d);
endtask

task automatic reg_read_check(input logic [12:0] addr, output logic [15:0] rd);
   logic hit;
   reg_access(1'b0, addr, 2'b11, 16'h0000, rd, hit);
   check_value("reg_hit", 32'(model_hit(addr)), 32'(hit));
   check_value("reg_rdata", 32'(model_read(addr)), 32'(rd));
endtask

task automatic read_all_regs();
   logic [15:0] rd;
   int          k;
   reg_read_check(`MMU_SR0_ADDR, rd);
   reg_read_check(`MMU_SR3_ADDR, rd);
   for (k = 0; k < 2*`MMU_PAGES; k++)
   begin
      reg_read_check(page_addr(k[3], 1'b1, k[2:0]), rd);
      reg_read_check(page_addr(k[3], 1'b0, k[2:0]), rd);
   end
endtask

task automatic xlate_check(input logic [15:0] va, input logic wr, input logic usr,
                           output logic abt);
   logic [21:0] exp_pa;
   logic        exp_abt;
   logic [21:0] pa;
   model_xlate(va, wr, usr, exp_pa, exp_abt);
   xl_access(va, wr, usr, pa, abt);
   check_value("xl_pa", 32'(exp_pa), 32'(pa));
   check_value("xl_abort", 32'(exp_abt), 32'(abt));
endtask

// four-phase rules on both channels
always @(posedge clk)
begin
   if (!sr_rst)
   begin
      if (reg_ack_d && reg_req_d)
         assert (reg_ack === 1'b1)
         else
         begin
            proto_errors++;
            $display("reg_ack dropped at %0t while reg_req was still high", $time);
         end
      if (reg_ack_d && !reg_req_d)
         assert (reg_ack === 1'b0)
         else
         begin
            proto_errors++;
            $display("reg_ack stayed high at %0t after reg_req fell", $time);
         end
      if (xl_ack_d && xl_req_d)
         assert (xl_ack === 1'b1)
         else
         begin
            proto_errors++;
            $display("xl_ack dropped at %0t while xl_req was still high", $time);
         end
      if (xl_ack_d && !xl_req_d)
         assert (xl_ack === 1'b0)
         else
         begin
            proto_errors++;
            $display("xl_ack stayed high at %0t after xl_req fell", $time);
         end
   end
   reg_req_d <= reg_req;
   reg_ack_d <= reg_ack;
   xl_req_d  <= xl_req;
   xl_ack_d  <= xl_ack;
end

initial
begin
   repeat (WDOG_CYCLES) @(posedge clk);
   $display("timeout after %0d cycles, an access never completed", WDOG_CYCLES);
   $display("Test failed");
   $finish;
end

initial
begin
   int          i;
   int          rnd;
   int          rnd2;
   logic [15:0] rd;
   logic        abt;
   sr_rst    <= 1'b1;
   reg_req   <= 1'b0;
   reg_we    <= 1'b0;
   reg_addr  <= 13'd0;
   reg_be    <= 2'b00;
   reg_wdata <= 16'h0000;
   xl_req    <= 1'b0;
   xl_write  <= 1'b0;
   xl_user   <= 1'b0;
   xl_va     <= 16'h0000;
   for (i = 0; i < 2*`MMU_PAGES; i++)
   begin
      m_par[i] = 16'h0000;
      m_pdr[i] = 16'h0000;
   end
   m_abt  = 3'b000;
   m_user = 1'b0;
   m_page = 3'b000;
   m_en   = 1'b0;
   m_22   = 1'b0;
   repeat (5) @(posedge clk);
   sr_rst <= 1'b0;
   @(posedge clk);

   // reset state
   check_value("reg_ack", 32'd0, 32'(reg_ack));
   check_value("xl_ack", 32'd0, 32'(xl_ack));
   check_value("xl_abort", 32'd0, 32'(xl_abort));
   read_all_regs();

   // random register writes then a full read back
   for (i = 0; i < N_RND; i++)
   begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      reg_write(page_addr(rnd[3], rnd[4], rnd[2:0]), rnd[6:5], rnd2[15:0]);
   end
   reg_write(`MMU_SR3_ADDR, 2'b11, 16'hffff);
   read_all_regs();
   reg_write(13'o17400, 2'b11, 16'hffff);          // undecoded
   reg_read_check(13'o17400, rd);
   reg_read_check(13'o12320, rd);                  // kernel set with bit 4 set

   // va passes through with mapping off
   for (i = 0; i < N_XL; i++)
   begin
      rnd = $random(seed);
      xlate_check(rnd[15:0], rnd[16], rnd[17], abt);
   end

   // full-length resident writable pages with mapping on
   for (i = 0; i < 2*`MMU_PAGES; i++)
   begin
      rnd = $random(seed);
      reg_write(page_addr(i[3], 1'b0, i[2:0]), 2'b11, 16'h7f06);
      reg_write(page_addr(i[3], 1'b1, i[2:0]), 2'b11, rnd[15:0]);
   end
   reg_write(`MMU_SR0_ADDR, 2'b11, 16'h0001);
   reg_write(`MMU_SR3_ADDR, 2'b11, 16'h0000);
   for (i = 0; i < N_XL; i++)
   begin
      rnd = $random(seed);
      xlate_check(rnd[15:0], rnd[16], rnd[17], abt);
   end
   reg_write(`MMU_SR3_ADDR, 2'b11, 16'h0010);      // 22-bit mapping
   for (i = 0; i < N_XL; i++)
   begin
      rnd = $random(seed);
      xlate_check(rnd[15:0], rnd[16], rnd[17], abt);
   end

   // non-resident kernel page 2
   reg_write(page_addr(1'b0, 1'b0, 3'd2), 2'b11, 16'h7f00);
   xlate_check({3'd2, 7'd4, 6'd1}, 1'b0, 1'b0, abt);
   check_value("xl_abort", 32'd1, 32'(abt));
   reg_read_check(`MMU_SR0_ADDR, rd);
   // second abort on read-only user page 5 leaves SR0 alone
   reg_write(page_addr(1'b1, 1'b0, 3'd5), 2'b11, 16'h7f02);
   xlate_check({3'd5, 7'd9, 6'd3}, 1'b1, 1'b1, abt);
   check_value("xl_abort", 32'd1, 32'(abt));
   reg_read_check(`MMU_SR0_ADDR, rd);
   reg_write(`MMU_SR0_ADDR, 2'b10, 16'h0000);      // clear reasons only
   xlate_check({3'd5, 7'd9, 6'd3}, 1'b1, 1'b1, abt);
   check_value("xl_abort", 32'd1, 32'(abt));
   reg_read_check(`MMU_SR0_ADDR, rd);
   reg_write(`MMU_SR0_ADDR, 2'b10, 16'h0000);
   // blk 20 beyond an upward page of length 10
   reg_write(page_addr(1'b0, 1'b0, 3'd6), 2'b11, 16'h0a06);
   xlate_check({3'd6, 7'd20, 6'd0}, 1'b0, 1'b0, abt);
   check_value("xl_abort", 32'd1, 32'(abt));
   reg_read_check(`MMU_SR0_ADDR, rd);
   reg_write(`MMU_SR0_ADDR, 2'b10, 16'h0000);
   // downward page from 100
   reg_write(page_addr(1'b0, 1'b0, 3'd7), 2'b11, 16'h640e);
   xlate_check({3'd7, 7'd50, 6'd7}, 1'b0, 1'b0, abt);
   check_value("xl_abort", 32'd1, 32'(abt));
   reg_read_check(`MMU_SR0_ADDR, rd);
   reg_write(`MMU_SR0_ADDR, 2'b10, 16'h0000);
   xlate_check({3'd7, 7'd120, 6'd7}, 1'b1, 1'b0, abt);
   check_value("xl_abort", 32'd0, 32'(abt));

   // W bit on kernel page 3
   reg_write(page_addr(1'b0, 1'b1, 3'd3), 2'b11, 16'h0123);
   reg_read_check(page_addr(1'b0, 1'b0, 3'd3), rd);
   check_value("reg_rdata[6]", 32'd0, 32'(rd[`PDR_W]));
   xlate_check({3'd3, 7'd5, 6'd9}, 1'b1, 1'b0, abt);
   reg_read_check(page_addr(1'b0, 1'b0, 3'd3), rd);
   check_value("reg_rdata[6]", 32'd1, 32'(rd[`PDR_W]));
   reg_write(page_addr(1'b0, 1'b1, 3'd3), 2'b01, 16'h0055);
   reg_read_check(page_addr(1'b0, 1'b0, 3'd3), rd);
   check_value("reg_rdata[6]", 32'd0, 32'(rd[`PDR_W]));
   reg_read_check(`MMU_SR0_ADDR, rd);

   $display("summary: %0d value errors, %0d handshake errors", errors, proto_errors);
   if (errors == 0 && proto_errors == 0)
      $display("Test passed");
   else
      $display("Test failed");
   $finish;
end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/mmu_pkg.sv
logic/mmu_ifs.sv
logic/mmu_bus_ctrl.sv
logic/mmu_page_regs.sv
logic/mmu_status_regs.sv
logic/mmu_xlate.sv
logic/mmu_top.sv
sim/tb_mmu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = tb_mmu
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "Test passed" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
